// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // datapath and register file
    localparam int DATA_W   = 16;
    localparam int NUM_REGS = 8;

    // issue queue
    localparam int IQ_DEPTH = 8;

    typedef logic [DATA_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // 16 tags cover the 11 instructions that can be in flight
    typedef logic [3:0] tag_t;
    typedef logic [3:0] op_t;

    // occupancy 0..IQ_DEPTH
    typedef logic [$clog2(IQ_DEPTH):0] iq_cnt_t;

    // register-register
    localparam op_t OP_ADD  = 4'd0;
    localparam op_t OP_SUB  = 4'd1;
    localparam op_t OP_AND  = 4'd2;
    localparam op_t OP_OR   = 4'd3;
    localparam op_t OP_XOR  = 4'd4;

    // shift amount from low 4 bits of source 2
    localparam op_t OP_SLL  = 4'd5;
    localparam op_t OP_SRL  = 4'd6;

    // signed compare, result 1 or 0
    localparam op_t OP_SLT  = 4'd7;

    // immediate forms
    localparam op_t OP_ADDI = 4'd8;
    localparam op_t OP_LUI  = 4'd9;

endpackage

`default_nettype wire

// File: verilog/register_state.sv
`timescale 1ns/100ps
`default_nettype none

module register_state import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  logic     ren_valid,
    input  reg_idx_t ren_rd,
    input  tag_t     ren_tag,
    input  logic     res_valid,
    input  tag_t     res_tag,
    input  reg_idx_t res_rd,
    input  word_t    res_data,
    output logic     rs1_ready,
    output word_t    rs1_data,
    output tag_t     rs1_tag,
    output logic     rs2_ready,
    output word_t    rs2_data,
    output tag_t     rs2_tag
);

    word_t               regs [NUM_REGS];
    tag_t                prod [NUM_REGS];
    logic [NUM_REGS-1:0] busy;
    logic                wb_hit;

    // only the latest producer may retire the register
    assign wb_hit = res_valid && busy[res_rd] && prod[res_rd] == res_tag;

    function automatic logic src_ready(reg_idx_t idx);
        return !busy[idx] || (res_valid && res_tag == prod[idx]);
    endfunction

    function automatic word_t src_data(reg_idx_t idx);
        return busy[idx] ? res_data : regs[idx];
    endfunction

    always_comb begin
        rs1_ready = src_ready(rs1_idx);
        rs1_data  = src_data(rs1_idx);
        rs1_tag   = prod[rs1_idx];
        rs2_ready = src_ready(rs2_idx);
        rs2_data  = src_data(rs2_idx);
        rs2_tag   = prod[rs2_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                prod[i] <= '0;
            end
        end else begin
            if (wb_hit) begin
                regs[res_rd] <= res_data;
                busy[res_rd] <= 1'b0;
            end
            // rename after writeback so it wins
            if (ren_valid) begin
                busy[ren_rd] <= 1'b1;
                prod[ren_rd] <= ren_tag;
            end
        end
    end

    a_result_hits_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid && prod[res_rd] == res_tag |-> busy[res_rd]
    );

endmodule

`default_nettype wire

// File: verilog/dispatch_decode.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_decode import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  op_t      in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  word_t    in_imm,
    input  logic     full,
    input  logic     rs1_ready,
    input  word_t    rs1_data,
    input  tag_t     rs1_tag,
    input  logic     rs2_ready,
    input  word_t    rs2_data,
    input  tag_t     rs2_tag,
    input  logic     res_valid,
    input  tag_t     res_tag,
    input  word_t    res_data,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output logic     ren_valid,
    output reg_idx_t ren_rd,
    output tag_t     ren_tag,
    output logic     disp_valid,
    output op_t      disp_op,
    output tag_t     disp_tag,
    output reg_idx_t disp_rd,
    output logic     disp_src1_ready,
    output tag_t     disp_src1_tag,
    output word_t    disp_src1_data,
    output logic     disp_src2_ready,
    output tag_t     disp_src2_tag,
    output word_t    disp_src2_data
);

    tag_t  next_tag;
    logic  src1_ready;
    word_t src1_data;
    tag_t  src1_tag;
    logic  src2_ready;
    word_t src2_data;
    tag_t  src2_tag;

    assign rs1_idx   = in_rs1;
    assign rs2_idx   = in_rs2;
    assign ren_valid = in_valid;
    assign ren_rd    = in_rd;
    assign ren_tag   = next_tag;

    // immediate forms override the looked-up sources
    always_comb begin
        src1_ready = rs1_ready;
        src1_data  = rs1_data;
        src1_tag   = rs1_tag;
        src2_ready = rs2_ready;
        src2_data  = rs2_data;
        src2_tag   = rs2_tag;
        if (in_op == OP_ADDI || in_op == OP_LUI) begin
            src2_ready = 1'b1;
            src2_data  = in_imm;
            src2_tag   = '0;
        end
        if (in_op == OP_LUI) begin
            src1_ready = 1'b1;
            src1_data  = '0;
            src1_tag   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_tag   <= '0;
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= in_valid;
            if (in_valid) begin
                next_tag <= next_tag + 4'd1;
            end
        end
    end

    // held entry keeps listening to the result bus
    always_ff @(posedge clk) begin
        if (in_valid) begin
            disp_op         <= in_op;
            disp_tag        <= next_tag;
            disp_rd         <= in_rd;
            disp_src1_ready <= src1_ready;
            disp_src1_tag   <= src1_tag;
            disp_src1_data  <= src1_data;
            disp_src2_ready <= src2_ready;
            disp_src2_tag   <= src2_tag;
            disp_src2_data  <= src2_data;
        end else if (res_valid) begin
            if (!disp_src1_ready && disp_src1_tag == res_tag) begin
                disp_src1_ready <= 1'b1;
                disp_src1_data  <= res_data;
            end
            if (!disp_src2_ready && disp_src2_tag == res_tag) begin
                disp_src2_ready <= 1'b1;
                disp_src2_data  <= res_data;
            end
        end
    end

    // source must respect full
    a_no_strobe_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> !full
    );

endmodule

`default_nettype wire

// File: verilog/alu_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

module alu_issue_queue import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     disp_valid,
    input  op_t      disp_op,
    input  tag_t     disp_tag,
    input  reg_idx_t disp_rd,
    input  logic     disp_src1_ready,
    input  tag_t     disp_src1_tag,
    input  word_t    disp_src1_data,
    input  logic     disp_src2_ready,
    input  tag_t     disp_src2_tag,
    input  word_t    disp_src2_data,
    input  logic     res_valid,
    input  tag_t     res_tag,
    input  word_t    res_data,
    output logic     full,
    output logic     iss_valid,
    output op_t      iss_op,
    output tag_t     iss_tag,
    output reg_idx_t iss_rd,
    output word_t    iss_a,
    output word_t    iss_b
);

    typedef logic [$clog2(IQ_DEPTH)-1:0] iq_idx_t;

    // index 0 holds the oldest entry
    op_t      q_op   [IQ_DEPTH];
    tag_t     q_tag  [IQ_DEPTH];
    reg_idx_t q_rd   [IQ_DEPTH];
    logic     q_s1r  [IQ_DEPTH];
    tag_t     q_s1t  [IQ_DEPTH];
    word_t    q_s1d  [IQ_DEPTH];
    logic     q_s2r  [IQ_DEPTH];
    tag_t     q_s2t  [IQ_DEPTH];
    word_t    q_s2d  [IQ_DEPTH];
    iq_cnt_t  cnt;

    // after wakeup
    logic     w_s1r  [IQ_DEPTH];
    word_t    w_s1d  [IQ_DEPTH];
    logic     w_s2r  [IQ_DEPTH];
    word_t    w_s2d  [IQ_DEPTH];
    logic     in_s1r;
    word_t    in_s1d;
    logic     in_s2r;
    word_t    in_s2d;

    logic     sel_found;
    iq_idx_t  sel_idx;
    iq_idx_t  tail;
    iq_cnt_t  cnt_next;

    assign full = cnt >= iq_cnt_t'(IQ_DEPTH - 1);

    // tag wakeup on stored and incoming sources
    always_comb begin
        for (int j = 0; j < IQ_DEPTH; j++) begin
            w_s1r[j] = q_s1r[j];
            w_s1d[j] = q_s1d[j];
            w_s2r[j] = q_s2r[j];
            w_s2d[j] = q_s2d[j];
            if (res_valid && !q_s1r[j] && q_s1t[j] == res_tag) begin
                w_s1r[j] = 1'b1;
                w_s1d[j] = res_data;
            end
            if (res_valid && !q_s2r[j] && q_s2t[j] == res_tag) begin
                w_s2r[j] = 1'b1;
                w_s2d[j] = res_data;
            end
        end
        in_s1r = disp_src1_ready;
        in_s1d = disp_src1_data;
        in_s2r = disp_src2_ready;
        in_s2d = disp_src2_data;
        if (res_valid && !disp_src1_ready && disp_src1_tag == res_tag) begin
            in_s1r = 1'b1;
            in_s1d = res_data;
        end
        if (res_valid && !disp_src2_ready && disp_src2_tag == res_tag) begin
            in_s2r = 1'b1;
            in_s2d = res_data;
        end
    end

    // top-down scan leaves the lowest ready index
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int j = IQ_DEPTH - 1; j >= 0; j--) begin
            if (iq_cnt_t'(j) < cnt && w_s1r[j] && w_s2r[j]) begin
                sel_found = 1'b1;
                sel_idx   = iq_idx_t'(j);
            end
        end
    end

    assign cnt_next = cnt - iq_cnt_t'(sel_found) + iq_cnt_t'(disp_valid);
    assign tail     = iq_idx_t'(cnt - iq_cnt_t'(sel_found));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            iss_valid <= 1'b0;
        end else begin
            cnt       <= cnt_next;
            iss_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_found) begin
            iss_op  <= q_op[sel_idx];
            iss_tag <= q_tag[sel_idx];
            iss_rd  <= q_rd[sel_idx];
            iss_a   <= w_s1d[sel_idx];
            iss_b   <= w_s2d[sel_idx];
        end
        // entries above the issued one move down
        for (int j = 0; j < IQ_DEPTH - 1; j++) begin
            if (sel_found && iq_idx_t'(j) >= sel_idx) begin
                q_op[j]  <= q_op[j+1];
                q_tag[j] <= q_tag[j+1];
                q_rd[j]  <= q_rd[j+1];
                q_s1r[j] <= w_s1r[j+1];
                q_s1t[j] <= q_s1t[j+1];
                q_s1d[j] <= w_s1d[j+1];
                q_s2r[j] <= w_s2r[j+1];
                q_s2t[j] <= q_s2t[j+1];
                q_s2d[j] <= w_s2d[j+1];
            end else begin
                q_s1r[j] <= w_s1r[j];
                q_s1d[j] <= w_s1d[j];
                q_s2r[j] <= w_s2r[j];
                q_s2d[j] <= w_s2d[j];
            end
        end
        q_s1r[IQ_DEPTH-1] <= w_s1r[IQ_DEPTH-1];
        q_s1d[IQ_DEPTH-1] <= w_s1d[IQ_DEPTH-1];
        q_s2r[IQ_DEPTH-1] <= w_s2r[IQ_DEPTH-1];
        q_s2d[IQ_DEPTH-1] <= w_s2d[IQ_DEPTH-1];
        // append last so it overrides the shift at the tail slot
        if (disp_valid) begin
            q_op[tail]  <= disp_op;
            q_tag[tail] <= disp_tag;
            q_rd[tail]  <= disp_rd;
            q_s1r[tail] <= in_s1r;
            q_s1t[tail] <= disp_src1_tag;
            q_s1d[tail] <= in_s1d;
            q_s2r[tail] <= in_s2r;
            q_s2t[tail] <= disp_src2_tag;
            q_s2d[tail] <= in_s2d;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        disp_valid |-> cnt != iq_cnt_t'(IQ_DEPTH)
    );

endmodule

`default_nettype wire

// File: verilog/alu_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module alu_pipe import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     iss_valid,
    input  op_t      iss_op,
    input  tag_t     iss_tag,
    input  reg_idx_t iss_rd,
    input  word_t    iss_a,
    input  word_t    iss_b,
    output logic     res_valid,
    output tag_t     res_tag,
    output reg_idx_t res_rd,
    output word_t    res_data
);

    // stage 1
    logic     s1_valid;
    op_t      s1_op;
    tag_t     s1_tag;
    reg_idx_t s1_rd;
    word_t    s1_a;
    word_t    s1_b;
    word_t    alu_out;

    always_comb begin
        case (s1_op)
            OP_ADD:  alu_out = s1_a + s1_b;
            OP_SUB:  alu_out = s1_a - s1_b;
            OP_AND:  alu_out = s1_a & s1_b;
            OP_OR:   alu_out = s1_a | s1_b;
            OP_XOR:  alu_out = s1_a ^ s1_b;
            OP_SLL:  alu_out = s1_a << s1_b[3:0];
            OP_SRL:  alu_out = s1_a >> s1_b[3:0];
            OP_SLT:  alu_out = word_t'($signed(s1_a) < $signed(s1_b));
            OP_ADDI: alu_out = s1_a + s1_b;
            OP_LUI:  alu_out = s1_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= iss_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op    <= iss_op;
        s1_tag   <= iss_tag;
        s1_rd    <= iss_rd;
        s1_a     <= iss_a;
        s1_b     <= iss_b;
        res_tag  <= s1_tag;
        res_rd   <= s1_rd;
        res_data <= alu_out;
    end

endmodule

`default_nettype wire

// File: verilog/ooo_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_issue_top import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  op_t      in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  word_t    in_imm,
    output logic     full,
    output logic     res_valid,
    output tag_t     res_tag,
    output reg_idx_t res_rd,
    output word_t    res_data
);

    // operand lookup
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     rs1_ready;
    word_t    rs1_data;
    tag_t     rs1_tag;
    logic     rs2_ready;
    word_t    rs2_data;
    tag_t     rs2_tag;

    // rename
    logic     ren_valid;
    reg_idx_t ren_rd;
    tag_t     ren_tag;

    // dispatch entry
    logic     disp_valid;
    op_t      disp_op;
    tag_t     disp_tag;
    reg_idx_t disp_rd;
    logic     disp_src1_ready;
    tag_t     disp_src1_tag;
    word_t    disp_src1_data;
    logic     disp_src2_ready;
    tag_t     disp_src2_tag;
    word_t    disp_src2_data;

    // issue
    logic     iss_valid;
    op_t      iss_op;
    tag_t     iss_tag;
    reg_idx_t iss_rd;
    word_t    iss_a;
    word_t    iss_b;

    dispatch_decode i_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_op           (in_op),
        .in_rd           (in_rd),
        .in_rs1          (in_rs1),
        .in_rs2          (in_rs2),
        .in_imm          (in_imm),
        .full            (full),
        .rs1_ready       (rs1_ready),
        .rs1_data        (rs1_data),
        .rs1_tag         (rs1_tag),
        .rs2_ready       (rs2_ready),
        .rs2_data        (rs2_data),
        .rs2_tag         (rs2_tag),
        .res_valid       (res_valid),
        .res_tag         (res_tag),
        .res_data        (res_data),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .ren_valid       (ren_valid),
        .ren_rd          (ren_rd),
        .ren_tag         (ren_tag),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_tag        (disp_tag),
        .disp_rd         (disp_rd),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_data  (disp_src1_data),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_data  (disp_src2_data)
    );

    register_state i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .ren_valid (ren_valid),
        .ren_rd    (ren_rd),
        .ren_tag   (ren_tag),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .rs1_ready (rs1_ready),
        .rs1_data  (rs1_data),
        .rs1_tag   (rs1_tag),
        .rs2_ready (rs2_ready),
        .rs2_data  (rs2_data),
        .rs2_tag   (rs2_tag)
    );

    alu_issue_queue i_iq (
        .clk             (clk),
        .rst_n           (rst_n),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_tag        (disp_tag),
        .disp_rd         (disp_rd),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_data  (disp_src1_data),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_data  (disp_src2_data),
        .res_valid       (res_valid),
        .res_tag         (res_tag),
        .res_data        (res_data),
        .full            (full),
        .iss_valid       (iss_valid),
        .iss_op          (iss_op),
        .iss_tag         (iss_tag),
        .iss_rd          (iss_rd),
        .iss_a           (iss_a),
        .iss_b           (iss_b)
    );

    alu_pipe i_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_tag   (iss_tag),
        .iss_rd    (iss_rd),
        .iss_a     (iss_a),
        .iss_b     (iss_b),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_ooo_issue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_issue import ooo_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int FIELDS     = 7;
    localparam int MAX_INSTR  = 64;
    localparam int NUM_TAGS   = 16;
    localparam logic [15:0] END_MARK = 16'hffff;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    op_t      in_op;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    word_t    in_imm;
    logic     full;
    logic     res_valid;
    tag_t     res_tag;
    reg_idx_t res_rd;
    word_t    res_data;

    // gap, op, rd, rs1, rs2, imm, expected per instruction
    logic [15:0] stim_mem [0:MAX_INSTR*FIELDS-1];
    int          num_instr;
    int          gap_sum;
    int          watchdog_ns;
    logic        stim_loaded;
    logic        started;

    // per-tag expectations, written by the driver
    word_t    exp_data   [NUM_TAGS];
    reg_idx_t exp_rd     [NUM_TAGS];
    int       slot_index [NUM_TAGS];
    int       slot_issued [NUM_TAGS];
    int       issued_total;

    // written by the result monitor only
    int       slot_done [NUM_TAGS];
    int       done_total;
    int       max_done;
    int       ooo_count;
    logic     full_seen;
    int       error_count;

    ooo_issue_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_rd     (in_rd),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_imm    (in_imm),
        .full      (full),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_stim();
        $readmemh("tb/ooo_issue_stim.txt", stim_mem);
        num_instr = 0;
        gap_sum   = 0;
        for (int n = 0; n < MAX_INSTR; n++) begin
            if ($isunknown(stim_mem[n*FIELDS]) || stim_mem[n*FIELDS] == END_MARK) begin
                break;
            end
            num_instr++;
            gap_sum += int'(stim_mem[n*FIELDS]);
        end
        if (num_instr == 0) begin
            abort_run("stim file holds no instructions");
        end
        watchdog_ns = (num_instr + gap_sum) * 20 * CLK_PERIOD;
        stim_loaded = 1'b1;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    // strobe instruction n and note what its tag must return
    task automatic send_instr(input int n);
        int   base;
        tag_t t;
        base = n * FIELDS;
        t    = n[3:0];
        if (slot_issued[t] != slot_done[t]) begin
            abort_run($sformatf("tag %0d reused while its result is outstanding", t));
        end
        exp_data[t]   = stim_mem[base+6];
        exp_rd[t]     = stim_mem[base+2][2:0];
        slot_index[t] = n;
        slot_issued[t]++;
        issued_total++;
        in_op    = stim_mem[base+1][3:0];
        in_rd    = stim_mem[base+2][2:0];
        in_rs1   = stim_mem[base+3][2:0];
        in_rs2   = stim_mem[base+4][2:0];
        in_imm   = stim_mem[base+5];
        in_valid = 1'b1;
        started  = 1'b1;
    endtask

    task automatic check_result();
        tag_t t;
        t = res_tag;
        if (slot_issued[t] == slot_done[t]) begin
            abort_run($sformatf("result with tag %0d has no instruction waiting for it", t));
        end else begin
            check_value($sformatf("tag %0d rd", t), word_t'(res_rd), word_t'(exp_rd[t]));
            check_value($sformatf("tag %0d data", t), res_data, exp_data[t]);
            slot_done[t]++;
            done_total++;
            // a younger instruction already finished
            if (slot_index[t] < max_done) begin
                ooo_count++;
            end else begin
                max_done = slot_index[t];
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (full) begin
                full_seen = 1'b1;
            end
            if (!started && (res_valid !== 1'b0 || full !== 1'b0)) begin
                abort_run("res_valid or full is not low between reset and the first strobe");
            end
            if (res_valid) begin
                check_result();
            end
        end
    end

    initial begin
        wait (stim_loaded);
        #(watchdog_ns);
        $display("Error at %0t ns: timeout with results still outstanding", $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_op        = '0;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        stim_loaded  = 1'b0;
        started      = 1'b0;
        issued_total = 0;
        done_total   = 0;
        max_done     = -1;
        ooo_count    = 0;
        full_seen    = 1'b0;
        error_count  = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            slot_issued[t] = 0;
            slot_done[t]   = 0;
            slot_index[t]  = 0;
            exp_data[t]    = '0;
            exp_rd[t]      = '0;
        end
        load_stim();

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int n = 0; n < num_instr; n++) begin
            repeat (stim_mem[n*FIELDS]) next_cycle();
            while (full) begin
                next_cycle();
            end
            send_instr(n);
            next_cycle();
        end

        wait (done_total == issued_total);
        repeat (10) @(posedge clk);
        if (ooo_count == 0) begin
            abort_run("no result completed ahead of an older instruction");
        end
        if (!full_seen) begin
            abort_run("full never rose while the queue was being filled");
        end
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "errors seen");
        end
    end

endmodule

`default_nettype wire

// File: ooo_issue.f
verilog/ooo_pkg.sv
verilog/register_state.sv
verilog/dispatch_decode.sv
verilog/alu_issue_queue.sv
verilog/alu_pipe.sv
verilog/ooo_issue_top.sv
tb/tb_ooo_issue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ooo_issue
FILELIST  ?= ooo_issue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/ooo_issue_stim.txt
// gap op rd rs1 rs2 imm expected, all hex, one instruction per line
// gap ffff ends the list
// all opcodes on ready operands
3 9 1 0 0 1234 1234
0 9 2 0 0 00f3 00f3
0 9 3 0 0 8005 8005
6 0 4 1 2 0000 1327
0 1 5 1 2 0000 1141
0 2 6 1 3 0000 0004
0 3 7 1 3 0000 9235
0 4 0 2 3 0000 80f6
0 5 6 1 2 0000 91a0
0 6 7 3 2 0000 1000
0 7 4 3 1 0000 0001
0 7 5 1 3 0000 0000
0 8 1 1 0 ffff 1233
// back-to-back raw chain
4 0 2 1 1 0000 2466
0 1 3 2 7 0000 1466
0 4 2 3 2 0000 3000
0 5 3 2 4 0000 6000
0 8 3 3 0 0010 6010
// stalled chain with independent work behind it
0 0 1 3 3 0000 c020
0 1 1 1 7 0000 b020
0 3 0 1 4 0000 b021
0 9 5 0 0 00aa 00aa
0 4 6 5 7 0000 10aa
0 9 7 0 0 0f0f 0f0f
// waw on r2, later reader must see the lui
2 8 1 1 0 0001 b021
0 6 2 1 4 0000 5810
0 9 2 0 0 0007 0007
0 0 3 2 2 0000 000e
6 3 4 2 3 0000 000f
// long chain back to back, queue fills
2 8 5 5 0 0001 00ab
0 0 5 5 5 0000 0156
0 4 5 5 4 0000 0159
0 8 5 5 0 0100 0259
0 5 5 5 4 0000 8000
0 7 6 5 4 0000 0001
0 0 5 5 6 0000 8001
0 6 5 5 6 0000 4000
0 1 5 5 4 0000 3ff1
0 2 6 5 3 0000 0000
0 3 7 5 6 0000 3ff1
0 9 0 0 0 5555 5555
0 8 1 0 0 0001 5556
0 4 2 7 1 0000 6aa7
a 0 3 2 5 0000 aa98
ffff 0 0 0 0 0 0
